// ==== sb_defs.svh ====
// ##################################################
// Geometry of the store-path data memory.
// The way bit sits just above the word index, so the
// memory spans 2 ways of 1024 words. Higher address
// bits are ignored and addresses wrap.
// ##################################################
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// Sets per way, log2.
`define SB_LG_SETS 6

// Words per cache block, log2. Sets and block words
// together give the word index, address bits 11 to 2.
`define SB_LG_BLOCK_WORDS 4

// Bytes per data word, so the data path is 32 bits.
`define SB_DATA_BYTES 4

`endif

// ==== cache_types_pkg.sv ====
// ##################################################
// Types shared by the store buffer, the memory and
// the APB port. Word locations carry the way bit
// (address bit 12) above a 10-bit word index.
// Sub-word load alignment is not supported.
// ##################################################
`include "sb_defs.svh"

package cache_types_pkg;

  localparam int unsigned DATA_BYTES = `SB_DATA_BYTES;
  localparam int unsigned DATA_W     = 8 * DATA_BYTES;
  localparam int unsigned OFFSET_W   = $clog2(DATA_BYTES);
  localparam int unsigned INDEX_W    = `SB_LG_SETS + `SB_LG_BLOCK_WORDS;

  typedef struct packed {
    logic               way;
    logic [INDEX_W-1:0] index;
  } sb_loc_t;

  typedef struct packed {
    sb_loc_t                loc;
    logic [DATA_W-1:0]      data;
    logic [DATA_BYTES-1:0]  mask;  // Byte write enables.
  } sb_entry_t;

  typedef struct packed {
    logic                   we;
    sb_loc_t                loc;
    logic [DATA_W-1:0]      data;
    logic [DATA_BYTES-1:0]  mask;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]      data;
    logic [DATA_BYTES-1:0]  valid;  // Per byte.
  } sb_bypass_t;

  // Upper address bits are dropped here.
  function automatic sb_loc_t addr_to_loc(input logic [31:0] addr);
    sb_loc_t loc;
    loc.way   = addr[OFFSET_W + INDEX_W];
    loc.index = addr[OFFSET_W +: INDEX_W];
    return loc;
  endfunction

endpackage

// ==== apb_pkg.sv ====
// ##################################################
// APB4 request and response bundles, 32-bit address
// and data. Only psel, penable, pwrite, paddr,
// pwdata and pstrb are carried; pprot is not used.
// ##################################################
package apb_pkg;

  localparam int unsigned APB_ADDR_W = 32;
  localparam int unsigned APB_DATA_W = 32;
  localparam int unsigned APB_STRB_W = APB_DATA_W / 8;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic                  pready;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

// ==== store_buffer_queue.sv ====
// ##################################################
// Two-slot shift queue of store entries.
// el1 is the older slot, el0 the newer one. The head
// passes data_i through when the queue is empty.
// No full flag: never push into a full queue
// without popping in the same cycle.
// ##################################################
`timescale 1ns/1ps

module store_buffer_queue import cache_types_pkg::*; (
  input  logic       clock_i
  ,input  logic      rst_n_i
  ,input  sb_entry_t data_i
  ,input  logic      push_i
  ,input  logic      pop_i
  ,output sb_entry_t head_o
  ,output sb_entry_t el0_o
  ,output sb_entry_t el1_o
  ,output logic [1:0] count_o
);

  sb_entry_t  el0_r, el1_r;
  logic [1:0] count_r;
  logic       el0_load, el1_load;

  // Slots that are, or become, empty take new data freely.
  assign el1_load = pop_i | (count_r == 2'd0);
  assign el0_load = pop_i | (count_r != 2'd2);

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      count_r <= 2'd0;
    end else begin
      count_r <= count_r + {1'b0, push_i} - {1'b0, pop_i};
    end
  end

  always_ff @(posedge clock_i) begin
    if (el1_load) begin
      el1_r <= (count_r == 2'd2) ? el0_r : data_i;  // Shift on pop.
    end
    if (el0_load) begin
      el0_r <= data_i;
    end
  end

  assign head_o  = (count_r != 2'd0) ? el1_r : data_i;
  assign el0_o   = el0_r;
  assign el1_o   = el1_r;
  assign count_o = count_r;

endmodule

// ==== store_buffer.sv ====
// ##################################################
// Store buffer of up to two pending word stores.
// Drains one store per cycle while the memory port
// is free; an arriving store meeting an empty buffer
// and a free port is written through.
// Bypass data is valid the cycle after the capture
// strobe and holds until the next capture.
// ##################################################
`timescale 1ns/1ps

module store_buffer import cache_types_pkg::*; (
  input  logic        clock_i
  ,input  logic       rst_n_i
  ,input  sb_entry_t  store_i
  ,input  logic       store_valid_i
  ,input  logic       mem_free_i
  ,input  sb_loc_t    load_loc_i
  ,input  logic       load_capture_i
  ,output mem_req_t   mem_req_o
  ,output logic       full_o
  ,output sb_bypass_t bypass_o
);

  sb_entry_t  head, el0, el1;
  logic [1:0] count;
  logic       drain;
  logic       el0_valid, el1_valid;
  logic       hit_in, hit_el0, hit_el1;
  sb_bypass_t bypass_n, bypass_r;

  assign drain = mem_free_i & ((count != 2'd0) | store_valid_i);

  store_buffer_queue queue0 (
    .clock_i  (clock_i)
    ,.rst_n_i (rst_n_i)
    ,.data_i  (store_i)
    ,.push_i  (store_valid_i)
    ,.pop_i   (drain)
    ,.head_o  (head)
    ,.el0_o   (el0)
    ,.el1_o   (el1)
    ,.count_o (count)
  );

  assign el0_valid = (count == 2'd2);  // Newer slot.
  assign el1_valid = (count != 2'd0);  // Older slot.
  assign full_o    = el0_valid;

  always_comb begin
    mem_req_o.we   = drain;
    mem_req_o.loc  = head.loc;
    mem_req_o.data = head.data;
    mem_req_o.mask = head.mask;
  end

  assign hit_in  = store_valid_i & (store_i.loc == load_loc_i);
  assign hit_el0 = el0_valid & (el0.loc == load_loc_i);
  assign hit_el1 = el1_valid & (el1.loc == load_loc_i);

  // Youngest matching byte wins.
  always_comb begin
    bypass_n = '0;
    for (int b = 0; b < DATA_BYTES; b++) begin
      if (hit_in && store_i.mask[b]) begin
        bypass_n.data[8*b +: 8] = store_i.data[8*b +: 8];
        bypass_n.valid[b]       = 1'b1;
      end else if (hit_el0 && el0.mask[b]) begin
        bypass_n.data[8*b +: 8] = el0.data[8*b +: 8];
        bypass_n.valid[b]       = 1'b1;
      end else if (hit_el1 && el1.mask[b]) begin
        bypass_n.data[8*b +: 8] = el1.data[8*b +: 8];
        bypass_n.valid[b]       = 1'b1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (load_capture_i) begin
      bypass_r <= bypass_n;
    end
  end

  assign bypass_o = bypass_r;

endmodule

// ==== data_sram.sv ====
// ##################################################
// Single-port word memory, two ways of 1024 words.
// Writes are byte masked at the clock edge. A read
// returns data the cycle after the request and the
// output holds during write cycles.
// Contents are undefined after power-up.
// ##################################################
`timescale 1ns/1ps

module data_sram import cache_types_pkg::*; (
  input  logic              clock_i
  ,input  mem_req_t         req_i
  ,output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned ADDR_W = $bits(sb_loc_t);
  localparam int unsigned DEPTH  = 2 ** ADDR_W;

  logic [DATA_BYTES-1:0][7:0] mem_r [DEPTH];
  logic [ADDR_W-1:0]          addr;

  assign addr = req_i.loc;  // Way bit on top.

  always_ff @(posedge clock_i) begin
    if (req_i.we) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (req_i.mask[b]) begin
          mem_r[addr][b] <= req_i.data[8*b +: 8];
        end
      end
    end else begin
      rdata_o <= mem_r[addr];
    end
  end

endmodule

// ==== apb_dcache_port.sv ====
// ##################################################
// APB4 slave for the data cache store path.
// Writes complete in the first access cycle unless
// the store buffer is full. Reads always take two
// access cycles. pslverr is tied low.
// The master must hold the access phase until pready.
// ##################################################
`timescale 1ns/1ps

module apb_dcache_port
  import apb_pkg::*;
  import cache_types_pkg::*;
(
  input  logic              clock_i
  ,input  logic             rst_n_i
  ,input  apb_req_t         apb_i
  ,output apb_rsp_t         apb_o
  ,input  logic             sb_full_i
  ,input  sb_bypass_t       bypass_i
  ,input  logic [DATA_W-1:0] mem_rdata_i
  ,output sb_entry_t        store_o
  ,output logic             store_valid_o
  ,output sb_loc_t          load_loc_o
  ,output logic             load_capture_o
  ,output logic             read_issue_o
  ,output logic             mem_free_o
);

  typedef enum logic {
    ST_IDLE,
    ST_RD_DATA
  } state_e;

  state_e            state_r, state_n;
  logic              access;
  sb_loc_t           loc;
  logic [DATA_W-1:0] rdata;

  assign access = apb_i.psel & apb_i.penable;
  assign loc    = addr_to_loc(apb_i.paddr);

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      ST_IDLE: begin
        if (access && !apb_i.pwrite) begin
          state_n = ST_RD_DATA;  // Memory read goes out now.
        end
      end
      ST_RD_DATA: begin
        state_n = ST_IDLE;
      end
      default: state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  assign read_issue_o   = (state_r == ST_IDLE) & access & ~apb_i.pwrite;
  assign load_capture_o = read_issue_o;
  assign load_loc_o     = loc;
  assign mem_free_o     = ~read_issue_o;

  // Accepted writes go straight to the store buffer.
  assign store_valid_o = (state_r == ST_IDLE) & access & apb_i.pwrite & ~sb_full_i;
  assign store_o.loc   = loc;
  assign store_o.data  = apb_i.pwdata;
  assign store_o.mask  = apb_i.pstrb;

  // Forwarded bytes override the memory word.
  always_comb begin
    rdata = mem_rdata_i;
    for (int b = 0; b < DATA_BYTES; b++) begin
      if (bypass_i.valid[b]) begin
        rdata[8*b +: 8] = bypass_i.data[8*b +: 8];
      end
    end
  end

  assign apb_o.pready  = store_valid_o | (state_r == ST_RD_DATA);
  assign apb_o.prdata  = rdata;
  assign apb_o.pslverr = 1'b0;

endmodule

// ==== dcache_store_top.sv ====
// ##################################################
// Store path of a small data cache behind one APB4
// slave port. Loads take the memory port first and
// buffered stores drain in the free cycles.
// No tags or refill: the memory is the whole store.
// ##################################################
`timescale 1ns/1ps

module dcache_store_top
  import apb_pkg::*;
  import cache_types_pkg::*;
(
  input  logic      clock_i
  ,input  logic     rst_n_i
  ,input  apb_req_t apb_i
  ,output apb_rsp_t apb_o
);

  sb_entry_t         store;
  logic              store_valid;
  sb_loc_t           load_loc;
  logic              load_capture;
  logic              read_issue;
  logic              mem_free;
  logic              sb_full;
  sb_bypass_t        bypass;
  mem_req_t          sb_req, rd_req, mem_req;
  logic [DATA_W-1:0] mem_rdata;

  apb_dcache_port port0 (
    .clock_i         (clock_i)
    ,.rst_n_i        (rst_n_i)
    ,.apb_i          (apb_i)
    ,.apb_o          (apb_o)
    ,.sb_full_i      (sb_full)
    ,.bypass_i       (bypass)
    ,.mem_rdata_i    (mem_rdata)
    ,.store_o        (store)
    ,.store_valid_o  (store_valid)
    ,.load_loc_o     (load_loc)
    ,.load_capture_o (load_capture)
    ,.read_issue_o   (read_issue)
    ,.mem_free_o     (mem_free)
  );

  store_buffer sb0 (
    .clock_i         (clock_i)
    ,.rst_n_i        (rst_n_i)
    ,.store_i        (store)
    ,.store_valid_i  (store_valid)
    ,.mem_free_i     (mem_free)
    ,.load_loc_i     (load_loc)
    ,.load_capture_i (load_capture)
    ,.mem_req_o      (sb_req)
    ,.full_o         (sb_full)
    ,.bypass_o       (bypass)
  );

  assign rd_req  = '{we: 1'b0, loc: load_loc, data: '0, mask: '0};
  assign mem_req = read_issue ? rd_req : sb_req;  // Loads win the port.

  data_sram sram0 (
    .clock_i  (clock_i)
    ,.req_i   (mem_req)
    ,.rdata_o (mem_rdata)
  );

endmodule

// ==== store_buffer_checker.sv ====
// ##################################################
// Concurrent checks on the store buffer, bound into
// every store_buffer instance. Reset is synchronous,
// so emptiness is checked one edge after reset.
// ##################################################
`timescale 1ns/1ps

module store_buffer_checker (
  input  logic       clock_i
  ,input  logic      rst_n_i
  ,input  logic [1:0] count_i
  ,input  logic      full_i
  ,input  logic      push_i
  ,input  logic      pop_i
  ,input  logic      mem_we_i
  ,input  logic      load_capture_i
);

  count_in_range: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    count_i <= 2'd2)
    else $error("store buffer holds more than two entries");

  no_push_when_full: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (full_i && push_i) |-> pop_i)
    else $error("store pushed into a full buffer without a drain");

  // The load capture strobe marks the cycle in which the port reads memory.
  drain_needs_port: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    mem_we_i |-> !load_capture_i)
    else $error("drain write issued while the memory port is busy");

  empty_after_reset: assert property (@(posedge clock_i)
    !rst_n_i |=> (count_i == 2'd0))
    else $error("store buffer not empty after reset");

endmodule

// ==== tb_dcache_store.sv ====
// ##################################################
// Testbench for the cache store path over APB4.
// A fixed table runs first, then random traffic over
// 16 words spread across both ways. Expected read
// data comes from a shadow memory of accepted writes.
// ##################################################
`timescale 1ns/1ps
`include "sb_defs.svh"

module tb_dcache_store import apb_pkg::*; ();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int TABLE_LEN      = 15;
  localparam int INIT_OPS       = 16;
  localparam int RANDOM_OPS     = 300;
  localparam int TIMEOUT_CYCLES = 40 * (TABLE_LEN + INIT_OPS + RANDOM_OPS) + RESET_CYCLES;
  localparam int unsigned SEED  = 82247;

  typedef struct packed {
    logic                      write;
    logic [3:0]                word;
    logic [31:0]               data;
    logic [`SB_DATA_BYTES-1:0] strb;
  } tb_op_t;

  logic        clock_i;
  logic        rst_n_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] shadow [16];
  int          error_count;
  int          check_count;

  // Partial strobes on word 1 check byte merging in write order.
  tb_op_t op_table [TABLE_LEN] = '{
    '{1'b1, 4'd0, 32'hA5A5_0F0F, 4'hF},
    '{1'b0, 4'd0, 32'h0, 4'h0},
    '{1'b1, 4'd1, 32'h1111_1111, 4'hF},
    '{1'b1, 4'd1, 32'hAABB_CCDD, 4'b0011},
    '{1'b1, 4'd1, 32'h9988_7766, 4'b0110},
    '{1'b0, 4'd1, 32'h0, 4'h0},
    '{1'b1, 4'd10, 32'h0BAD_F00D, 4'hF},
    '{1'b1, 4'd11, 32'hCAFE_BABE, 4'hF},
    '{1'b0, 4'd10, 32'h0, 4'h0},
    '{1'b1, 4'd4, 32'h1234_5678, 4'hF},
    '{1'b0, 4'd11, 32'h0, 4'h0},
    '{1'b0, 4'd4, 32'h0, 4'h0},
    '{1'b1, 4'd10, 32'hFFFF_FFFF, 4'b1000},
    '{1'b0, 4'd10, 32'h0, 4'h0},
    '{1'b0, 4'd0, 32'h0, 4'h0}
  };

  dcache_store_top dut0 (
    .clock_i  (clock_i)
    ,.rst_n_i (rst_n_i)
    ,.apb_i   (apb_req)
    ,.apb_o   (apb_rsp)
  );

  bind store_buffer store_buffer_checker chk0 (
    .clock_i         (clock_i)
    ,.rst_n_i        (rst_n_i)
    ,.count_i        (count)
    ,.full_i         (full_o)
    ,.push_i         (store_valid_i)
    ,.pop_i          (drain)
    ,.mem_we_i       (mem_req_o.we)
    ,.load_capture_i (load_capture_i)
  );

  always #(CLK_PERIOD / 2) clock_i = ~clock_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [`SB_DATA_BYTES-1:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < `SB_DATA_BYTES; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Word bit 3 selects the way (address bit 12).
  function automatic logic [31:0] word_addr(input logic [3:0] word);
    return {19'd0, word[3], 7'd0, word[2:0], 2'b00};
  endfunction

  // Ends at the negedge where pready is seen; the next posedge completes it.
  task automatic apb_transfer(input tb_op_t op, output logic [31:0] rdata,
                              output int cycles);
    apb_req_t req;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = op.write;
    req.paddr   = word_addr(op.word);
    req.pwdata  = op.data;
    req.pstrb   = op.strb;
    @(posedge clock_i);
    apb_req <= req;
    @(posedge clock_i);
    apb_req.penable <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clock_i);
      cycles++;
    end while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    check_value("pslverr", 32'(apb_rsp.pslverr), 32'h0);
  endtask

  task automatic run_op(input tb_op_t op);
    logic [31:0] rdata;
    int          cycles;
    apb_transfer(op, rdata, cycles);
    if (op.write) begin
      shadow[op.word] = merge_bytes(shadow[op.word], op.data, op.strb);
    end else begin
      check_value("prdata", rdata, shadow[op.word]);
      check_value("read access cycles", 32'(cycles), 32'd2);
    end
  endtask

  initial begin
    tb_op_t op;
    clock_i     = 1'b0;
    rst_n_i     = 1'b0;
    apb_req     = '0;
    error_count = 0;
    check_count = 0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge clock_i);
    rst_n_i <= 1'b1;
    repeat (2) begin
      @(negedge clock_i);
      check_value("pready", 32'(apb_rsp.pready), 32'h0);  // Idle bus after reset.
    end
    for (int i = 0; i < TABLE_LEN; i++) begin
      run_op(op_table[i]);
    end
    for (int w = 0; w < INIT_OPS; w++) begin
      op.write = 1'b1;
      op.word  = 4'(w);
      op.data  = $urandom;
      op.strb  = 4'hF;
      run_op(op);
    end
    for (int i = 0; i < RANDOM_OPS; i++) begin
      op.write = 1'($urandom % 2);
      op.word  = 4'($urandom % 16);
      op.data  = $urandom;
      op.strb  = 4'($urandom);
      run_op(op);
    end
    @(posedge clock_i);
    apb_req <= '0;
    repeat (4) @(posedge clock_i);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
cache_types_pkg.sv
apb_pkg.sv
store_buffer_queue.sv
store_buffer.sv
data_sram.sv
apb_dcache_port.sv
dcache_store_top.sv
store_buffer_checker.sv
tb_dcache_store.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_dcache_store
FLIST     := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --timing --assert --top-module $(TOP) -f $(FLIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# The run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
